//--- source/instrPkg.sv
package instrPkg;

	// instruction register
	localparam int INSTR_W = 32;

	// class field sits in ir[27:25]
	localparam int CLASS_W   = 3;
	localparam int CLASS_LSB = 25;

	// set on a branch that also saves the return address
	localparam int LINK_BIT = 20;

	// classes handled by this unit
	// any other code in the class field is treated as unsupported
	typedef enum logic [CLASS_W-1:0] {
		DATA_SHIFT = 3'b000,
		DATA_IMM   = 3'b001,
		BRANCH     = 3'b101
	} instrClass_t;

endpackage

//--- source/ctrlPkg.sv
package ctrlPkg;

	// state register
	localparam int STATE_W = 4;

	// encodings follow the microprogram step numbers
	typedef enum logic [STATE_W-1:0] {
		RESET         = 4'd0,
		FETCH_ADDR    = 4'd1,
		FETCH_INC     = 4'd2,
		FETCH_WAIT    = 4'd3,
		DECODE        = 4'd4,
		DP_IMM_EXEC   = 4'd5,
		DP_IMM_FLAGS  = 4'd6,
		DP_SHIFT_EXEC = 4'd7,
		BR_TARGET     = 4'd8,
		BR_UPDATE     = 4'd9,
		BR_LINK       = 4'd10
	} state_t;

	// alu operation codes
	localparam int ALU_OP_W = 5;

	// pass operand A
	localparam logic [ALU_OP_W-1:0] ALU_PASS      = 5'b10000;
	// pass and increment, used for pc + 4
	localparam logic [ALU_OP_W-1:0] ALU_PASS_INC  = 5'b10001;
	localparam logic [ALU_OP_W-1:0] ALU_ADD_FLAGS = 5'b10011;
	// adder used on the branch path
	localparam logic [ALU_OP_W-1:0] ALU_BR_ADD    = 5'b00100;

	// shifter
	localparam int SHIFT_W = 3;

	// rotate the 8-bit immediate
	localparam logic [SHIFT_W-1:0] SHIFT_ROT_IMM   = 3'b001;
	// sign extend and scale the 24-bit offset
	localparam logic [SHIFT_W-1:0] SHIFT_BR_OFFSET = 3'b100;

	// memory access size
	localparam int MEM_TYPE_W = 2;

	localparam logic [MEM_TYPE_W-1:0] MEM_WORD = 2'b10;

	// datapath mux selects
	localparam int MUXA_W = 2;
	localparam int MUXB_W = 1;
	localparam int MUXC_W = 3;
	localparam int MUXF_W = 2;
	localparam int MUXJ_W = 2;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
	input  logic [instrPkg::INSTR_W-1:0] ir,
	output ctrlPkg::state_t              entryState
);

	instrPkg::instrClass_t instrClass;
	logic                  link;

	assign instrClass = instrPkg::instrClass_t'(
		ir[instrPkg::CLASS_LSB +: instrPkg::CLASS_W]);

	assign link = ir[instrPkg::LINK_BIT];

	// first execute step of each supported class
	always_comb
	begin
		case (instrClass)
			instrPkg::DATA_IMM:
			begin
				entryState = ctrlPkg::DP_IMM_EXEC;
			end
			instrPkg::DATA_SHIFT:
			begin
				entryState = ctrlPkg::DP_SHIFT_EXEC;
			end
			instrPkg::BRANCH:
			begin
				// link saves the return address before the target step
				if (link)
					entryState = ctrlPkg::BR_LINK;
				else
					entryState = ctrlPkg::BR_TARGET;
			end
			default:
			begin
				// unsupported, drop it and fetch the next one
				entryState = ctrlPkg::FETCH_ADDR;
			end
		endcase
	end

endmodule

//--- source/stateSequencer.sv
`timescale 1ns/100ps

module stateSequencer (
	input  logic            CLK,
	input  logic            rst,
	input  logic            moc,
	input  logic            cond,
	input  ctrlPkg::state_t entryState,
	output ctrlPkg::state_t state
);

	ctrlPkg::state_t nextState;

	always_ff @(posedge CLK)
	begin
		if (rst)
			state <= ctrlPkg::RESET;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			ctrlPkg::RESET:
				nextState = ctrlPkg::FETCH_ADDR;

			// fetch
			ctrlPkg::FETCH_ADDR:
				nextState = ctrlPkg::FETCH_INC;
			ctrlPkg::FETCH_INC:
				nextState = ctrlPkg::FETCH_WAIT;
			ctrlPkg::FETCH_WAIT:
			begin
				// hold the read until memory reports completion
				if (moc)
					nextState = ctrlPkg::DECODE;
				else
					nextState = ctrlPkg::FETCH_WAIT;
			end

			ctrlPkg::DECODE:
			begin
				// failed condition turns the instruction into a no-op
				if (cond)
					nextState = entryState;
				else
					nextState = ctrlPkg::FETCH_ADDR;
			end

			// data processing
			ctrlPkg::DP_IMM_EXEC:
				nextState = ctrlPkg::DP_IMM_FLAGS;
			ctrlPkg::DP_IMM_FLAGS:
				nextState = ctrlPkg::FETCH_ADDR;
			ctrlPkg::DP_SHIFT_EXEC:
				nextState = ctrlPkg::FETCH_ADDR;

			// branch
			ctrlPkg::BR_LINK:
				nextState = ctrlPkg::BR_TARGET;
			ctrlPkg::BR_TARGET:
				nextState = ctrlPkg::BR_UPDATE;
			ctrlPkg::BR_UPDATE:
				nextState = ctrlPkg::FETCH_ADDR;

			// unused codes restart through the clear step
			default:
				nextState = ctrlPkg::RESET;
		endcase
	end

endmodule

//--- source/controlWordRom.sv
`timescale 1ns/100ps

module controlWordRom (
	input  ctrlPkg::state_t                  state,
	output logic                             clr,
	output logic                             rfLd,
	output logic                             irLd,
	output logic                             marLd,
	output logic                             frLd,
	output logic                             memRw,
	output logic                             memMov,
	output logic                             shiftEn,
	output logic                             muxD,
	output logic                             muxB,
	output logic                             muxH,
	output logic                             muxI,
	output logic                             branchSel,
	output logic [ctrlPkg::MEM_TYPE_W-1:0]   memType,
	output logic [ctrlPkg::MUXA_W-1:0]       muxA,
	output logic [ctrlPkg::MUXC_W-1:0]       muxC,
	output logic [ctrlPkg::MUXF_W-1:0]       muxF,
	output logic [ctrlPkg::MUXJ_W-1:0]       muxJ,
	output logic [ctrlPkg::SHIFT_W-1:0]      shiftType,
	output logic [ctrlPkg::ALU_OP_W-1:0]     aluOp
);

	always_comb
	begin
		clr       = 1'b0;
		rfLd      = 1'b0;
		irLd      = 1'b0;
		marLd     = 1'b0;
		frLd      = 1'b0;
		memRw     = 1'b0;
		memMov    = 1'b0;
		shiftEn   = 1'b0;
		muxD      = 1'b0;
		muxB      = 1'b0;
		muxH      = 1'b0;
		muxI      = 1'b0;
		branchSel = 1'b0;
		memType   = '0;
		muxA      = '0;
		muxC      = '0;
		muxF      = '0;
		muxJ      = '0;
		shiftType = '0;
		aluOp     = '0;

		case (state)
			ctrlPkg::RESET:
			begin
				clr = 1'b1;
			end
			// mar <= pc
			ctrlPkg::FETCH_ADDR:
			begin
				marLd = 1'b1;
				muxA  = 2'd2;
				muxD  = 1'b1;
				aluOp = ctrlPkg::ALU_PASS;
			end
			// pc <= pc + 4 while the word read starts
			ctrlPkg::FETCH_INC:
			begin
				rfLd    = 1'b1;
				memRw   = 1'b1;
				memMov  = 1'b1;
				memType = ctrlPkg::MEM_WORD;
				muxA    = 2'd2;
				muxC    = 3'd3;
				muxD    = 1'b1;
				aluOp   = ctrlPkg::ALU_PASS_INC;
			end
			ctrlPkg::FETCH_WAIT:
			begin
				irLd    = 1'b1;
				memRw   = 1'b1;
				memMov  = 1'b1;
				memType = ctrlPkg::MEM_WORD;
			end
			ctrlPkg::DP_IMM_EXEC:
			begin
				rfLd      = 1'b1;
				muxB      = 1'b1;
				muxC      = 3'd4;
				muxF      = 2'd3;
				muxD      = 1'b1;
				shiftEn   = 1'b1;
				shiftType = ctrlPkg::SHIFT_ROT_IMM;
				aluOp     = ctrlPkg::ALU_ADD_FLAGS;
			end
			ctrlPkg::DP_IMM_FLAGS:
			begin
				rfLd = 1'b1;
				frLd = 1'b1;
				muxJ = 2'd1;
			end
			ctrlPkg::DP_SHIFT_EXEC:
			begin
				rfLd = 1'b1;
				frLd = 1'b1;
				muxB = 1'b1;
				muxH = 1'b1;
				muxI = 1'b1;
			end
			// lr <= pc
			ctrlPkg::BR_LINK:
			begin
				rfLd      = 1'b1;
				muxA      = 2'd3;
				muxC      = 3'd4;
				muxD      = 1'b1;
				muxJ      = 2'd1;
				branchSel = 1'b1;
				aluOp     = ctrlPkg::ALU_BR_ADD;
			end
			ctrlPkg::BR_TARGET:
			begin
				rfLd      = 1'b1;
				frLd      = 1'b1;
				muxB      = 1'b1;
				muxC      = 3'd4;
				muxD      = 1'b1;
				muxF      = 2'd3;
				muxJ      = 2'd3;
				shiftEn   = 1'b1;
				shiftType = ctrlPkg::SHIFT_BR_OFFSET;
				aluOp     = ctrlPkg::ALU_ADD_FLAGS;
			end
			// pc <= pc + offset
			ctrlPkg::BR_UPDATE:
			begin
				rfLd      = 1'b1;
				muxA      = 2'd2;
				muxC      = 3'd3;
				muxD      = 1'b1;
				muxJ      = 2'd1;
				branchSel = 1'b1;
				aluOp     = ctrlPkg::ALU_BR_ADD;
			end
			// decode and unused codes drive nothing
			default:
			begin
				clr = 1'b0;
			end
		endcase
	end

endmodule

//--- source/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input  logic                             CLK,
	input  logic                             rst,
	input  logic                             moc,
	input  logic                             cond,
	input  logic [instrPkg::INSTR_W-1:0]     ir,
	output logic                             clr,
	output logic                             rfLd,
	output logic                             irLd,
	output logic                             marLd,
	output logic                             frLd,
	output logic                             memRw,
	output logic                             memMov,
	output logic                             shiftEn,
	output logic                             muxD,
	output logic                             muxB,
	output logic                             muxH,
	output logic                             muxI,
	output logic                             branchSel,
	output logic [ctrlPkg::MEM_TYPE_W-1:0]   memType,
	output logic [ctrlPkg::MUXA_W-1:0]       muxA,
	output logic [ctrlPkg::MUXC_W-1:0]       muxC,
	output logic [ctrlPkg::MUXF_W-1:0]       muxF,
	output logic [ctrlPkg::MUXJ_W-1:0]       muxJ,
	output logic [ctrlPkg::SHIFT_W-1:0]      shiftType,
	output logic [ctrlPkg::ALU_OP_W-1:0]     aluOp
);

	ctrlPkg::state_t entryState;
	ctrlPkg::state_t state;

	instrDecoder i_instrDecoder (
		.ir         (ir),
		.entryState (entryState)
	);

	stateSequencer i_stateSequencer (
		.CLK        (CLK),
		.rst        (rst),
		.moc        (moc),
		.cond       (cond),
		.entryState (entryState),
		.state      (state)
	);

	// outputs are a pure function of the state register
	controlWordRom i_controlWordRom (
		.state     (state),
		.clr       (clr),
		.rfLd      (rfLd),
		.irLd      (irLd),
		.marLd     (marLd),
		.frLd      (frLd),
		.memRw     (memRw),
		.memMov    (memMov),
		.shiftEn   (shiftEn),
		.muxD      (muxD),
		.muxB      (muxB),
		.muxH      (muxH),
		.muxI      (muxI),
		.branchSel (branchSel),
		.memType   (memType),
		.muxA      (muxA),
		.muxC      (muxC),
		.muxF      (muxF),
		.muxJ      (muxJ),
		.shiftType (shiftType),
		.aluOp     (aluOp)
	);

endmodule

//--- dv/controlUnit_asserts.sv
`timescale 1ns/100ps

module controlUnit_asserts (
	input logic                           CLK,
	input logic                           rst,
	input logic                           moc,
	input logic                           cond,
	input logic [instrPkg::INSTR_W-1:0]   ir,
	input logic                           clr,
	input logic                           rfLd,
	input logic                           irLd,
	input logic                           marLd,
	input logic                           frLd,
	input logic                           memRw,
	input logic                           memMov,
	input logic                           shiftEn,
	input logic                           muxD,
	input logic                           muxB,
	input logic                           muxH,
	input logic                           muxI,
	input logic                           branchSel,
	input logic [ctrlPkg::MEM_TYPE_W-1:0] memType,
	input logic [ctrlPkg::MUXA_W-1:0]     muxA,
	input logic [ctrlPkg::MUXC_W-1:0]     muxC,
	input logic [ctrlPkg::MUXF_W-1:0]     muxF,
	input logic [ctrlPkg::MUXJ_W-1:0]     muxJ,
	input logic [ctrlPkg::SHIFT_W-1:0]    shiftType,
	input logic [ctrlPkg::ALU_OP_W-1:0]   aluOp
);

	int                           failCount = 0;
	string                        firstMsg;
	logic [instrPkg::CLASS_W-1:0] instrClass;
	logic                         idle;
	logic                         taken;

	assign instrClass = ir[instrPkg::CLASS_LSB +: instrPkg::CLASS_W];
	// decode step drives no field at all
	assign idle = ({clr, rfLd, irLd, marLd, frLd, memRw, memMov, shiftEn, muxD, muxB, muxH,
		muxI, branchSel, memType, muxA, muxC, muxF, muxJ, shiftType, aluOp} == '0);
	assign taken = idle && cond;

	task automatic noteFailure(input string msg);
		if (failCount == 0)
			firstMsg = msg;
		failCount++;
		$error("%s", msg);
	endtask

	// reset
	assert property (@(posedge CLK) $fell(rst) |-> (clr && !(rfLd || irLd || marLd || frLd)))
		else noteFailure("clear step missing after reset release");
	assert property (@(posedge CLK) $fell(rst) |=> (marLd && !clr))
		else noteFailure("fetch address step does not follow the clear step");
	// fetch and decode
	assert property (@(posedge CLK) disable iff (rst)
		marLd |=> (rfLd && aluOp == ctrlPkg::ALU_PASS_INC))
		else noteFailure("pc increment step missing after marLd");
	assert property (@(posedge CLK) disable iff (rst)
		(rfLd && aluOp == ctrlPkg::ALU_PASS_INC) |=> (irLd && memMov))
		else noteFailure("instruction read missing after pc increment");
	assert property (@(posedge CLK) disable iff (rst) (irLd && !moc) |=> (irLd && memMov))
		else noteFailure("instruction read ended before moc");
	assert property (@(posedge CLK) disable iff (rst) (irLd && moc) |=> idle)
		else noteFailure("decode step does not follow moc");
	assert property (@(posedge CLK) disable iff (rst) (idle && !cond) |=> marLd)
		else noteFailure("failed condition did not return to fetch");
	// data processing
	assert property (@(posedge CLK) disable iff (rst) (taken && instrClass == instrPkg::DATA_IMM)
		|=> (rfLd && shiftType == ctrlPkg::SHIFT_ROT_IMM))
		else noteFailure("immediate execute step missing");
	assert property (@(posedge CLK) disable iff (rst)
		(rfLd && shiftType == ctrlPkg::SHIFT_ROT_IMM) |=> (rfLd && frLd))
		else noteFailure("flag update step missing after immediate execute");
	assert property (@(posedge CLK) disable iff (rst)
		(rfLd && frLd && $past(rfLd && shiftType == ctrlPkg::SHIFT_ROT_IMM)) |=> marLd)
		else noteFailure("immediate sequence did not return to fetch");
	assert property (@(posedge CLK) disable iff (rst)
		(taken && instrClass == instrPkg::DATA_SHIFT) |=> (rfLd && frLd && muxH))
		else noteFailure("shifted register execute step missing");
	assert property (@(posedge CLK) disable iff (rst) (rfLd && frLd && muxH) |=> marLd)
		else noteFailure("shifted register sequence did not return to fetch");
	// branch
	assert property (@(posedge CLK) disable iff (rst)
		(taken && instrClass == instrPkg::BRANCH && ir[instrPkg::LINK_BIT])
		|=> (rfLd && muxA == 2'd3))
		else noteFailure("link step missing on branch with link");
	assert property (@(posedge CLK) disable iff (rst)
		(taken && instrClass == instrPkg::BRANCH && !ir[instrPkg::LINK_BIT])
		|=> (frLd && shiftType == ctrlPkg::SHIFT_BR_OFFSET))
		else noteFailure("target step missing on branch");
	assert property (@(posedge CLK) disable iff (rst)
		(rfLd && muxA == 2'd3) |=> (frLd && shiftType == ctrlPkg::SHIFT_BR_OFFSET))
		else noteFailure("target step does not follow link step");
	assert property (@(posedge CLK) disable iff (rst)
		(frLd && shiftType == ctrlPkg::SHIFT_BR_OFFSET) |=> (branchSel && muxA == 2'd2))
		else noteFailure("pc update step does not follow target step");
	assert property (@(posedge CLK) disable iff (rst) (branchSel && muxA == 2'd2) |=> marLd)
		else noteFailure("branch did not return to fetch");
	assert property (@(posedge CLK) disable iff (rst) (taken && !(instrClass inside
		{instrPkg::DATA_SHIFT, instrPkg::DATA_IMM, instrPkg::BRANCH})) |=> marLd)
		else noteFailure("unsupported class did not return to fetch");
	// exclusivity
	assert property (@(posedge CLK) $onehot0({irLd, marLd, clr}))
		else noteFailure("irLd, marLd and clr overlap");
	assert property (@(posedge CLK) memMov |-> (rfLd || irLd))
		else noteFailure("memMov without rfLd or irLd");

endmodule

bind controlUnit controlUnit_asserts i_asserts (.*);

//--- dv/controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 3;
	localparam int INSTR_COUNT  = 200;
	// longest instruction takes 14 cycles with the full moc wait
	localparam int CYCLES_PER_INSTR = 16;

	logic                           CLK;
	logic                           rst;
	logic                           moc;
	logic                           cond;
	logic [instrPkg::INSTR_W-1:0]   ir;
	logic                           clr;
	logic                           rfLd;
	logic                           irLd;
	logic                           marLd;
	logic                           frLd;
	logic                           memRw;
	logic                           memMov;
	logic                           shiftEn;
	logic                           muxD;
	logic                           muxB;
	logic                           muxH;
	logic                           muxI;
	logic                           branchSel;
	logic [ctrlPkg::MEM_TYPE_W-1:0] memType;
	logic [ctrlPkg::MUXA_W-1:0]     muxA;
	logic [ctrlPkg::MUXC_W-1:0]     muxC;
	logic [ctrlPkg::MUXF_W-1:0]     muxF;
	logic [ctrlPkg::MUXJ_W-1:0]     muxJ;
	logic [ctrlPkg::SHIFT_W-1:0]    shiftType;
	logic [ctrlPkg::ALU_OP_W-1:0]   aluOp;

	logic [15:0] lfsr = 16'd33624;

	controlUnit i_dut (.*);

	// galois form of x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output logic [7:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			bits = {bits[6:0], lfsr[0]};
		end
	endtask

	initial
	begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial
	begin
		#((INSTR_COUNT * CYCLES_PER_INSTR + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the instructions did not complete in time");
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		wait (i_dut.i_asserts.failCount != 0);
		$display("CHECK FAILED at %0t: %s", $time, i_dut.i_asserts.firstMsg);
		$display("test failed");
		$fatal(1, "assertion failure");
	end

	initial
	begin
		logic [7:0]                   pick;
		logic [instrPkg::CLASS_W-1:0] instrClass;
		logic [2:0]                   mocDelay;

		rst  = 1'b1;
		moc  = 1'b0;
		cond = 1'b0;
		ir   = '0;
		repeat (RESET_CYCLES) @(negedge CLK);
		rst = 1'b0;

		for (int n = 0; n < INSTR_COUNT; n++)
		begin
			// a new instruction starts with the fetch address step
			do
				@(negedge CLK);
			while (!marLd);
			takeBits(2, pick);
			case (pick[1:0])
				2'd0: instrClass = instrPkg::DATA_SHIFT;
				2'd1: instrClass = instrPkg::DATA_IMM;
				2'd2: instrClass = instrPkg::BRANCH;
				default: instrClass = 3'b110;
			endcase
			ir = '0;
			ir[instrPkg::CLASS_LSB +: instrPkg::CLASS_W] = instrClass;
			takeBits(1, pick);
			ir[instrPkg::LINK_BIT] = pick[0];
			takeBits(1, pick);
			cond = pick[0];
			takeBits(3, pick);
			mocDelay = pick[2:0];

			// memory completes after mocDelay wait cycles
			do
				@(negedge CLK);
			while (!irLd);
			repeat (mocDelay) @(negedge CLK);
			moc = 1'b1;
			@(negedge CLK);
			moc = 1'b0;
		end

		// let the last instruction retire
		do
			@(negedge CLK);
		while (!marLd);
		@(negedge CLK);
		if (i_dut.i_asserts.failCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- controlUnit.f
source/instrPkg.sv
source/ctrlPkg.sv
source/instrDecoder.sv
source/stateSequencer.sv
source/controlWordRom.sv
source/controlUnit.sv
dv/controlUnit_asserts.sv
dv/controlUnitTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module controlUnitTb -f controlUnit.f \
	-o controlUnitSim

# a failing run still leaves its log for the search below
./obj_dir/controlUnitSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

grep -qx "test passed" sim.log
